/* design/afifo_settings.svh */
`ifndef AFIFO_SETTINGS_SVH
`define AFIFO_SETTINGS_SVH

////////////////////
// FIFO geometry
////////////////////

// Number of entries, must be a power of two
`define AFIFO_DEPTH 16

// Flip-flops in each Gray pointer crossing
`define AFIFO_SYNC_STAGES 2

// Margin values loaded at reset, one per domain
`define AFIFO_AF_MARGIN_RST 2
`define AFIFO_AE_MARGIN_RST 2

`endif

/* design/afifo_pkg.sv */
`default_nettype none
`include "afifo_settings.svh"

package afifo_pkg;

	// Pointer carries one wrap bit above the address
	localparam int ptr_w = $clog2(`AFIFO_DEPTH) + 1;

	typedef logic [ptr_w-1:0] ptr_t;

	// Margin never exceeds the depth minus one
	typedef logic [ptr_w-2:0] margin_t;

	// Payload word stored in the FIFO
	typedef struct packed {
		logic [3:0]  tag;
		logic [15:0] data;
		logic        last;
	} afifo_word_t;

	// Margin load request, one per domain
	typedef struct packed {
		logic    load;
		margin_t margin;
	} cfg_req_t;

	typedef struct packed {
		logic full;
		logic almost_full;
	} wr_status_t;

	typedef struct packed {
		logic empty;
		logic almost_empty;
	} rd_status_t;

endpackage

`default_nettype wire

/* design/afifo_ptr_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module afifo_ptr_sync import afifo_pkg::*; #(
	parameter int STAGES = 2
) (
	input  logic clk,
	input  logic rst_n,
	input  ptr_t gray_in,
	output ptr_t bin_out
);

	// Flop chain, index 0 samples the foreign domain
	ptr_t sync_q [STAGES];

	// Gray decode, each bit folds in all higher bits
	function automatic ptr_t gray2bin(input ptr_t g);
		ptr_t b;
		b[ptr_w-1] = g[ptr_w-1];
		for (int i = ptr_w - 2; i >= 0; i--) begin
			b[i] = b[i+1] ^ g[i];
		end
		return b;
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < STAGES; i++) begin
				sync_q[i] <= '0;
			end
		end else begin
			sync_q[0] <= gray_in;
			// Shift toward the settled end
			for (int i = 1; i < STAGES; i++) begin
				sync_q[i] <= sync_q[i-1];
			end
		end
	end

	// Binary form for the local level arithmetic
	assign bin_out = gray2bin(sync_q[STAGES-1]);

endmodule

`default_nettype wire

/* design/afifo_level_cfg.sv */
`timescale 1ns/1ps
`default_nettype none

module afifo_level_cfg import afifo_pkg::*; #(
	parameter int RST_MARGIN = 2
) (
	input  logic     clk,
	input  logic     rst_n,
	input  cfg_req_t cfg,
	output margin_t  margin
);

	////////////////////
	// Margin register
	////////////////////

	// Current threshold for the almost flag of this domain
	margin_t margin_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			// Default threshold from the settings header
			margin_q <= margin_t'(RST_MARGIN);
		end else if (cfg.load) begin
			// New threshold applies from this edge on
			margin_q <= cfg.margin;
		end
	end

	// Controller sees the registered value only
	assign margin = margin_q;

endmodule

`default_nettype wire

/* design/afifo_wr_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module afifo_wr_ctrl import afifo_pkg::*; (
	input  logic             wr_clk,
	input  logic             wr_rst_n,
	input  logic             write,
	input  ptr_t             rd_bin_sync,
	input  margin_t          af_margin,
	output logic             mem_we,
	output logic [ptr_w-2:0] wr_addr,
	output ptr_t             wr_gray,
	output wr_status_t       status
);

	// Level that means every entry is taken
	localparam ptr_t full_level = ptr_t'(1) << (ptr_w - 1);

	ptr_t wr_bin;
	ptr_t wr_bin_next;
	ptr_t wr_gray_next;
	ptr_t level_next;
	ptr_t af_level;
	logic accept;

	////////////////////
	// Pointer update
	////////////////////

	// Registered full blocks writes, so overflow is ignored
	assign accept = write && !status.full;

	assign wr_bin_next  = wr_bin + ptr_t'(accept);
	assign wr_gray_next = (wr_bin_next >> 1) ^ wr_bin_next;

	// Memory takes the word at the current slot
	assign mem_we  = accept;
	assign wr_addr = wr_bin[ptr_w-2:0];

	////////////////////
	// Level and flags
	////////////////////

	// Stale read pointer makes this level high, never low
	assign level_next = wr_bin_next - rd_bin_sync;

	// Almost full threshold
	assign af_level = full_level - ptr_t'(af_margin);

	always_ff @(posedge wr_clk or negedge wr_rst_n) begin
		if (!wr_rst_n) begin
			wr_bin  <= '0;
			wr_gray <= '0;
			status  <= '0;
		end else begin
			wr_bin  <= wr_bin_next;
			// Only the Gray copy crosses to the read side
			wr_gray <= wr_gray_next;
			// Flags follow the pointer of this same edge
			status.full        <= (level_next == full_level);
			status.almost_full <= (level_next >= af_level);
		end
	end

endmodule

`default_nettype wire

/* design/afifo_rd_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module afifo_rd_ctrl import afifo_pkg::*; (
	input  logic             rd_clk,
	input  logic             rd_rst_n,
	input  logic             read,
	input  ptr_t             wr_bin_sync,
	input  margin_t          ae_margin,
	output logic [ptr_w-2:0] rd_addr,
	output ptr_t             rd_gray,
	output rd_status_t       status
);

	ptr_t rd_bin;
	ptr_t rd_bin_next;
	ptr_t rd_gray_next;
	ptr_t level_next;
	logic pop;

	////////////////////
	// Pointer update
	////////////////////

	// Registered empty blocks reads, so underflow is ignored
	assign pop = read && !status.empty;

	assign rd_bin_next  = rd_bin + ptr_t'(pop);
	assign rd_gray_next = (rd_bin_next >> 1) ^ rd_bin_next;

	// Head word address from the registered pointer
	// so the oldest word shows without a read
	assign rd_addr = rd_bin[ptr_w-2:0];

	////////////////////
	// Level and flags
	////////////////////

	// Stale write pointer makes this level low, never high
	assign level_next = wr_bin_sync - rd_bin_next;

	always_ff @(posedge rd_clk or negedge rd_rst_n) begin
		if (!rd_rst_n) begin
			rd_bin  <= '0;
			rd_gray <= '0;
			// Nothing stored yet, both flags up
			status  <= '{empty: 1'b1, almost_empty: 1'b1};
		end else begin
			rd_bin  <= rd_bin_next;
			// Gray copy goes back to the write side
			rd_gray <= rd_gray_next;
			status.empty        <= (level_next == '0);
			status.almost_empty <= (level_next <= ptr_t'(ae_margin));
		end
	end

endmodule

`default_nettype wire

/* design/afifo_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module afifo_mem import afifo_pkg::*; #(
	parameter type word_t = afifo_word_t,
	parameter int  DEPTH  = 16
) (
	input  logic                     wr_clk,
	input  logic                     we,
	input  logic [$clog2(DEPTH)-1:0] wr_addr,
	input  logic [$clog2(DEPTH)-1:0] rd_addr,
	input  word_t                    wr_data,
	output word_t                    rd_data
);

	// Payload storage, contents undefined until written
	word_t mem [DEPTH];

	// Write port in the write clock domain
	always_ff @(posedge wr_clk) begin
		if (we) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// Asynchronous read port
	// pointer handshake keeps the slot stable while read
	assign rd_data = mem[rd_addr];

endmodule

`default_nettype wire

/* design/afifo_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "afifo_settings.svh"

module afifo_top import afifo_pkg::*; (
	input  logic        wr_clk,
	input  logic        wr_rst_n,
	input  logic        rd_clk,
	input  logic        rd_rst_n,
	input  logic        write,
	input  afifo_word_t wr_word,
	input  cfg_req_t    wr_cfg,
	output wr_status_t  wr_status,
	input  logic        read,
	input  cfg_req_t    rd_cfg,
	output afifo_word_t rd_word,
	output rd_status_t  rd_status
);

	// Memory address width
	localparam int addr_w = ptr_w - 1;

	logic              mem_we;
	logic [addr_w-1:0] wr_addr;
	logic [addr_w-1:0] rd_addr;
	ptr_t              wr_gray;
	ptr_t              rd_gray;
	ptr_t              wr_bin_sync;
	ptr_t              rd_bin_sync;
	margin_t           af_margin;
	margin_t           ae_margin;

	////////////////////
	// Write domain
	////////////////////

	afifo_level_cfg #(
		.RST_MARGIN(`AFIFO_AF_MARGIN_RST)
	) u_wr_cfg (
		.clk   (wr_clk),
		.rst_n (wr_rst_n),
		.cfg   (wr_cfg),
		.margin(af_margin)
	);

	// Read pointer into wr_clk
	afifo_ptr_sync #(
		.STAGES(`AFIFO_SYNC_STAGES)
	) u_rd_ptr_sync (
		.clk    (wr_clk),
		.rst_n  (wr_rst_n),
		.gray_in(rd_gray),
		.bin_out(rd_bin_sync)
	);

	afifo_wr_ctrl u_wr_ctrl (
		.wr_clk     (wr_clk),
		.wr_rst_n   (wr_rst_n),
		.write      (write),
		.rd_bin_sync(rd_bin_sync),
		.af_margin  (af_margin),
		.mem_we     (mem_we),
		.wr_addr    (wr_addr),
		.wr_gray    (wr_gray),
		.status     (wr_status)
	);

	////////////////////
	// Read domain
	////////////////////

	afifo_level_cfg #(
		.RST_MARGIN(`AFIFO_AE_MARGIN_RST)
	) u_rd_cfg (
		.clk   (rd_clk),
		.rst_n (rd_rst_n),
		.cfg   (rd_cfg),
		.margin(ae_margin)
	);

	// Write pointer into rd_clk
	afifo_ptr_sync #(
		.STAGES(`AFIFO_SYNC_STAGES)
	) u_wr_ptr_sync (
		.clk    (rd_clk),
		.rst_n  (rd_rst_n),
		.gray_in(wr_gray),
		.bin_out(wr_bin_sync)
	);

	afifo_rd_ctrl u_rd_ctrl (
		.rd_clk     (rd_clk),
		.rd_rst_n   (rd_rst_n),
		.read       (read),
		.wr_bin_sync(wr_bin_sync),
		.ae_margin  (ae_margin),
		.rd_addr    (rd_addr),
		.rd_gray    (rd_gray),
		.status     (rd_status)
	);

	////////////////////
	// Storage
	////////////////////

	afifo_mem #(
		.word_t(afifo_word_t),
		.DEPTH (`AFIFO_DEPTH)
	) u_mem (
		.wr_clk (wr_clk),
		.we     (mem_we),
		.wr_addr(wr_addr),
		.rd_addr(rd_addr),
		.wr_data(wr_word),
		.rd_data(rd_word)
	);

endmodule

`default_nettype wire

/* dv/afifo_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module afifo_assertions import afifo_pkg::*; (
	input logic       wr_clk, wr_rst_n, rd_clk, rd_rst_n, write,
	input wr_status_t wr_status,
	input rd_status_t rd_status,
	input ptr_t       wr_gray, rd_gray, wr_bin_sync, rd_bin_sync
);

	// Sticky markers, one per property
	logic wr_step_bad = 1'b0;
	logic rd_step_bad = 1'b0;
	logic hold_bad = 1'b0;
	logic full_bad = 1'b0;
	logic empty_bad = 1'b0;
	logic failed;

	assign failed = wr_step_bad | rd_step_bad | hold_bad | full_bad | empty_bad;

	////////////////////
	// Gray pointers
	////////////////////

	// One bit per step on each crossing pointer
	wr_gray_step: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
		$countones(wr_gray ^ $past(wr_gray)) <= 1)
	else begin
		$error("wr_gray changed more than one bit in a cycle");
		wr_step_bad = 1'b1;
	end

	rd_gray_step: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
		$countones(rd_gray ^ $past(rd_gray)) <= 1)
	else begin
		$error("rd_gray changed more than one bit in a cycle");
		rd_step_bad = 1'b1;
	end

	// Overflow attempt leaves the write pointer alone
	wr_hold_on_full: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
		(write && wr_status.full) |=> $stable(wr_gray))
	else begin
		$error("write pointer moved on a write while full");
		hold_bad = 1'b1;
	end

	////////////////////
	// Flag release
	////////////////////

	// Full drops only once a newer read pointer came through the synchronizer
	full_release: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
		$fell(wr_status.full) |-> $past(rd_bin_sync) != $past(rd_bin_sync, 2))
	else begin
		$error("full dropped without a synchronized read");
		full_bad = 1'b1;
	end

	// Same rule for empty on the read side
	empty_release: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
		$fell(rd_status.empty) |-> $past(wr_bin_sync) != $past(wr_bin_sync, 2))
	else begin
		$error("empty dropped without a synchronized write");
		empty_bad = 1'b1;
	end

endmodule

`default_nettype wire

/* dv/afifo_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "afifo_settings.svh"

module afifo_tb import afifo_pkg::*; ();

	localparam int DEPTH = `AFIFO_DEPTH;
	// Idle window after which every flag is exact
	localparam int SETTLE = 3 * `AFIFO_SYNC_STAGES + 4;
	// Loop bound for any wait on the DUT
	localparam int LIMIT = 4 * DEPTH + 4 * SETTLE;

	logic        wr_clk, rd_clk, wr_rst_n, rd_rst_n;
	logic        write, read;
	afifo_word_t wr_word, rd_word;
	cfg_req_t    wr_cfg, rd_cfg;
	wr_status_t  wr_status;
	rd_status_t  rd_status;

	// Reference queue and the margins it is judged with
	afifo_word_t model [$];
	margin_t     af_m, ae_m;
	// Separate generator state per clock domain
	logic [31:0] wr_seed, rd_seed;

	afifo_top DUT (.*);

	bind afifo_top afifo_assertions u_afifo_assertions (.*);

	// First bound assertion failure ends the run
	always @(posedge DUT.u_afifo_assertions.failed) begin
		stop_on_error("A bound assertion failed during the run");
	end

	initial begin
		rd_clk = 1'b0;
		forever #4 rd_clk = ~rd_clk;
	end

	initial begin
		wr_clk = 1'b0;
		forever #5.5 wr_clk = ~wr_clk;
	end

	////////////////////
	// Helpers
	////////////////////

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// Value in 0 .. n-1 from the upper state bits
	function automatic int pick(input logic [31:0] s, input int n);
		return int'(s[30:16]) % n;
	endfunction

	task automatic stop_on_error(input string line);
		$display("%s", line);
		$display("Verification failed");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_word(input afifo_word_t got, input afifo_word_t exp, input string what);
		if (got !== exp) begin
			stop_on_error($sformatf("Error at %0t: %s is %h/%h/%b, expected %h/%h/%b",
				$time, what, got.tag, got.data, got.last, exp.tag, exp.data, exp.last));
		end
	endtask

	task automatic check_wr_status(input wr_status_t got, input wr_status_t exp,
		input string what);
		if (got !== exp) begin
			stop_on_error($sformatf("Error at %0t: %s full/af %b%b, expected %b%b",
				$time, what, got.full, got.almost_full, exp.full, exp.almost_full));
		end
	endtask

	task automatic check_rd_status(input rd_status_t got, input rd_status_t exp,
		input string what);
		if (got !== exp) begin
			stop_on_error($sformatf("Error at %0t: %s empty/ae %b%b, expected %b%b",
				$time, what, got.empty, got.almost_empty, exp.empty, exp.almost_empty));
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp) begin
			stop_on_error($sformatf("Error at %0t: %s is %0d, expected %0d",
				$time, what, got, exp));
		end
	endtask

	////////////////////
	// Bus cycles
	////////////////////

	// Full seen now is what the next edge acts on
	task automatic wr_cycle(input logic do_write);
		@(posedge wr_clk);
		#1;
		wr_seed = lcg_next(wr_seed);
		write = do_write;
		wr_word = afifo_word_t'(wr_seed[30:10]);
		if (do_write && !wr_status.full) model.push_back(wr_word);
	endtask

	// Head word is compared before the edge that pops it
	task automatic rd_cycle(input logic do_read, output logic popped);
		@(posedge rd_clk);
		#1;
		read = do_read;
		popped = do_read && !rd_status.empty;
		if (popped && model.size() == 0) begin
			stop_on_error("Read side showed a word that was never written");
		end else if (popped) begin
			check_word(rd_word, model[0], "head word");
			void'(model.pop_front());
		end
	endtask

	task automatic settle();
		repeat (SETTLE) @(posedge wr_clk);
		@(posedge rd_clk);
		#1;
	endtask

	// Flag rules for the model level under the current margins
	task automatic check_flags(input string what);
		wr_status_t wr_exp;
		rd_status_t rd_exp;
		int         level;
		level = model.size();
		wr_exp.full = (level == DEPTH);
		wr_exp.almost_full = (level >= DEPTH - int'(af_m));
		rd_exp.empty = (level == 0);
		rd_exp.almost_empty = (level <= int'(ae_m));
		check_wr_status(wr_status, wr_exp, what);
		check_rd_status(rd_status, rd_exp, what);
	endtask

	task automatic random_traffic(input int wr_cycles, input int rd_cycles);
		int   wr_prob;
		int   rd_prob;
		logic popped;
		wr_seed = lcg_next(wr_seed);
		wr_prob = 20 + pick(wr_seed, 80);
		rd_seed = lcg_next(rd_seed);
		rd_prob = 20 + pick(rd_seed, 80);
		fork
			begin
				repeat (wr_cycles) begin
					wr_seed = lcg_next(wr_seed);
					wr_cycle(pick(wr_seed, 100) < wr_prob);
				end
				wr_cycle(1'b0);
			end
			begin
				repeat (rd_cycles) begin
					rd_seed = lcg_next(rd_seed);
					rd_cycle(pick(rd_seed, 100) < rd_prob, popped);
				end
				rd_cycle(1'b0, popped);
			end
		join
	endtask

	// Read until empty shows, counting every pop
	task automatic drain_and_check();
		int   expected;
		int   count;
		int   guard;
		logic popped;
		logic done;
		expected = model.size();
		count = 0;
		guard = 0;
		done = 1'b0;
		while (!done) begin
			rd_cycle(1'b1, popped);
			if (popped) count++;
			else done = 1'b1;
			guard++;
			if (guard > LIMIT) stop_on_error("Timeout: empty never rose while draining");
		end
		rd_cycle(1'b0, popped);
		check_count(count, expected, "words drained");
	endtask

	task automatic move_to_level(input int k);
		int   guard;
		logic popped;
		guard = 0;
		while (model.size() < k) begin
			wr_cycle(1'b1);
			guard++;
			if (guard > LIMIT) stop_on_error("Timeout: writes were not accepted");
		end
		wr_cycle(1'b0);
		guard = 0;
		while (model.size() > k) begin
			rd_cycle(1'b1, popped);
			guard++;
			if (guard > LIMIT) stop_on_error("Timeout: reads found the FIFO empty");
		end
		rd_cycle(1'b0, popped);
	endtask

	task automatic load_margins(input margin_t af, input margin_t ae);
		fork
			begin
				@(posedge wr_clk);
				#1;
				wr_cfg.load = 1'b1;
				wr_cfg.margin = af;
				@(posedge wr_clk);
				#1;
				wr_cfg.load = 1'b0;
			end
			begin
				@(posedge rd_clk);
				#1;
				rd_cfg.load = 1'b1;
				rd_cfg.margin = ae;
				@(posedge rd_clk);
				#1;
				rd_cfg.load = 1'b0;
			end
		join
		af_m = af;
		ae_m = ae;
	endtask

	////////////////////
	// Test sequence
	////////////////////

	initial begin
		wr_status_t wr_exp;
		rd_status_t rd_exp;
		logic       popped;
		$timeformat(-9, 1, " ns", 0);
		{wr_rst_n, rd_rst_n, write, read} = '0;
		wr_word = '0;
		wr_cfg = '0;
		rd_cfg = '0;
		wr_seed = 32'hdd6f;
		rd_seed = lcg_next(32'hdd6f);
		af_m = margin_t'(`AFIFO_AF_MARGIN_RST);
		ae_m = margin_t'(`AFIFO_AE_MARGIN_RST);
		repeat (16) @(posedge rd_clk);
		#1;
		wr_rst_n = 1'b1;
		rd_rst_n = 1'b1;

		// Nothing stored so only the read flags are up
		wr_exp = '0;
		rd_exp.empty = 1'b1;
		rd_exp.almost_empty = 1'b1;
		check_wr_status(wr_status, wr_exp, "write status after reset");
		check_rd_status(rd_status, rd_exp, "read status after reset");

		// Concurrent traffic with back-pressure
		repeat (4) begin
			random_traffic(200, 280);
			settle();
			check_flags("settled flags after traffic");
		end

		// Drain then read an empty FIFO
		drain_and_check();
		repeat (6) rd_cycle(1'b1, popped);
		rd_cycle(1'b0, popped);
		// Level zero sits below any margin
		rd_exp.empty = 1'b1;
		rd_exp.almost_empty = 1'b1;
		check_rd_status(rd_status, rd_exp, "read status after reads while empty");

		// Twice the depth in writes so that half must drop
		repeat (2 * DEPTH) wr_cycle(1'b1);
		wr_cycle(1'b0);
		check_count(model.size(), DEPTH, "words accepted by a fill");
		settle();
		check_flags("settled flags when full");
		drain_and_check();

		// New margins at several levels
		repeat (3) begin
			wr_seed = lcg_next(wr_seed);
			rd_seed = lcg_next(rd_seed);
			load_margins(margin_t'(wr_seed >> 16), margin_t'(rd_seed >> 16));
			repeat (3) begin
				wr_seed = lcg_next(wr_seed);
				move_to_level(pick(wr_seed, DEPTH + 1));
				settle();
				check_flags("settled flags after margin load");
			end
		end
		drain_and_check();

		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
+incdir+design
design/afifo_pkg.sv
design/afifo_ptr_sync.sv
design/afifo_level_cfg.sv
design/afifo_wr_ctrl.sv
design/afifo_rd_ctrl.sv
design/afifo_mem.sv
design/afifo_top.sv
dv/afifo_assertions.sv
dv/afifo_tb.sv

/* Makefile */
TOP := afifo_tb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module $(TOP)

# The run may stop early, the log decides the result
sim:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+100 > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "^Verification passed$$" $(LOG); then \
		echo "Simulation PASS"; \
	else \
		echo "Simulation FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
